/* test/rv_decoder_trace.txt */
// t op f3 f7 prd pop rs1 rs2 v1 v2 rnd tk mb ab | pc miss hold rfw mrd mwr uwr div
// wb lane op2 alu rs1byp rs2byp; all hex, rnd 1 replaces v1 v2 with random values
1 33 0 00 05 03 05 05 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 0 00 2 2
1 33 0 00 05 13 05 05 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 0 00 1 1
1 33 0 00 05 23 05 05 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 0 00 0 0
1 33 0 00 00 13 00 00 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 0 00 0 0
1 33 0 20 05 03 05 06 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 0 10 2 0
1 33 0 00 07 6f 03 07 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 0 00 0 1
2 63 0 00 00 13 01 02 5 5 0 0 0 0  1 1 0 0 0 0 0 0  0 0 0 00 0 0
2 63 0 00 00 13 01 02 5 5 0 1 0 0  0 0 0 0 0 0 0 0  0 0 0 00 0 0
2 63 0 00 00 13 01 02 5 6 0 1 0 0  3 1 0 0 0 0 0 0  0 0 0 00 0 0
2 63 0 00 00 13 01 02 5 6 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 00 0 0
2 63 1 00 00 13 01 02 5 6 0 0 0 0  1 1 0 0 0 0 0 0  0 0 0 01 0 0
2 63 1 00 00 13 01 02 5 6 0 1 0 0  0 0 0 0 0 0 0 0  0 0 0 01 0 0
2 63 1 00 00 13 01 02 7 7 0 1 0 0  3 1 0 0 0 0 0 0  0 0 0 01 0 0
2 63 1 00 00 13 01 02 7 7 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 01 0 0
2 63 4 00 00 13 01 02 ffffffff 1 0 0 0 0  1 1 0 0 0 0 0 0  0 0 0 04 0 0
2 63 4 00 00 13 01 02 ffffffff 1 0 1 0 0  0 0 0 0 0 0 0 0  0 0 0 04 0 0
2 63 4 00 00 13 01 02 1 ffffffff 0 1 0 0  3 1 0 0 0 0 0 0  0 0 0 04 0 0
2 63 4 00 00 13 01 02 1 ffffffff 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 04 0 0
2 63 5 00 00 13 01 02 1 ffffffff 0 0 0 0  1 1 0 0 0 0 0 0  0 0 0 05 0 0
2 63 5 00 00 13 01 02 1 ffffffff 0 1 0 0  0 0 0 0 0 0 0 0  0 0 0 05 0 0
2 63 5 00 00 13 01 02 ffffffff 1 0 1 0 0  3 1 0 0 0 0 0 0  0 0 0 05 0 0
2 63 5 00 00 13 01 02 ffffffff 1 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 05 0 0
2 63 6 00 00 13 01 02 1 ffffffff 0 0 0 0  1 1 0 0 0 0 0 0  0 0 0 06 0 0
2 63 6 00 00 13 01 02 1 ffffffff 0 1 0 0  0 0 0 0 0 0 0 0  0 0 0 06 0 0
2 63 6 00 00 13 01 02 ffffffff 1 0 1 0 0  3 1 0 0 0 0 0 0  0 0 0 06 0 0
2 63 6 00 00 13 01 02 ffffffff 1 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 06 0 0
2 63 7 00 00 13 01 02 ffffffff 1 0 0 0 0  1 1 0 0 0 0 0 0  0 0 0 07 0 0
2 63 7 00 00 13 01 02 ffffffff 1 0 1 0 0  0 0 0 0 0 0 0 0  0 0 0 07 0 0
2 63 7 00 00 13 01 02 1 ffffffff 0 1 0 0  3 1 0 0 0 0 0 0  0 0 0 07 0 0
2 63 7 00 00 13 01 02 1 ffffffff 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 07 0 0
3 03 2 00 00 13 03 00 0 0 1 0 1 0  4 0 1 0 1 0 0 0  1 0 1 00 0 0
3 03 2 00 00 13 03 00 0 0 1 0 1 0  4 0 1 0 1 0 0 0  1 0 1 00 0 0
3 03 2 00 00 13 03 00 0 0 1 0 0 0  0 0 0 1 1 0 0 0  1 0 1 00 0 0
3 03 4 00 00 13 03 00 0 0 1 0 0 0  0 0 0 1 1 0 0 0  3 0 1 00 0 0
3 03 1 00 00 13 03 00 0 0 1 0 0 0  0 0 0 1 1 0 0 0  6 0 1 00 0 0
3 03 0 00 00 13 03 00 0 0 1 0 0 0  0 0 0 1 1 0 0 0  5 0 1 00 0 0
3 03 5 00 00 13 03 00 0 0 1 0 0 0  0 0 0 1 1 0 0 0  4 0 1 00 0 0
3 23 2 00 00 13 03 04 0 0 1 0 1 0  4 0 1 0 0 1 0 0  0 0 2 00 0 0
3 23 2 00 00 13 03 04 0 0 1 0 0 0  0 0 0 0 0 1 0 0  0 0 2 00 0 0
4 23 0 00 00 13 03 04 0 0 1 0 0 0  4 0 1 0 1 0 0 0  0 1 2 00 0 0
4 23 0 00 00 13 03 04 0 0 1 0 0 0  0 0 0 0 0 0 1 0  0 1 2 00 0 0
4 23 1 00 00 13 03 04 0 0 1 0 0 0  4 0 1 0 1 0 0 0  0 2 2 00 0 0
4 23 1 00 00 13 03 04 0 0 1 0 0 0  0 0 0 0 0 0 1 0  0 2 2 00 0 0
4 33 0 00 00 13 01 02 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 0 00 0 0
5 33 4 01 00 13 01 02 0 0 1 0 0 0  4 0 1 0 0 0 0 1  0 0 0 0c 0 0
5 33 4 01 00 13 01 02 0 0 1 0 0 1  0 0 0 1 0 0 0 0  0 0 0 0c 0 0
5 33 6 01 00 13 01 02 0 0 1 0 0 0  4 0 1 0 0 0 0 1  0 0 0 0e 0 0
5 33 6 01 00 13 01 02 0 0 1 0 0 1  0 0 0 1 0 0 0 0  0 0 0 0e 0 0
5 33 1 01 00 13 01 02 0 0 1 0 0 0  0 0 0 1 0 0 0 0  7 0 0 09 0 0
5 33 3 01 00 13 01 02 0 0 1 0 0 0  0 0 0 1 0 0 0 0  7 0 0 0b 0 0
5 33 0 01 00 13 01 02 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 0 08 0 0
6 37 0 00 00 13 01 02 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 4 00 0 0
6 17 0 00 00 13 01 02 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 3 00 0 0
6 6f 0 00 00 13 01 02 0 0 1 0 0 0  0 0 0 1 0 0 0 0  2 0 0 00 0 0
6 13 1 00 00 13 01 02 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 1 01 0 0
6 13 5 20 00 13 01 02 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 1 15 0 0
6 13 0 20 00 13 01 02 0 0 1 0 0 0  0 0 0 1 0 0 0 0  0 0 1 00 0 0
6 67 0 00 00 13 01 02 0 0 1 0 0 0  2 1 0 1 0 0 0 0  2 0 1 00 0 0
6 73 0 00 00 13 01 02 0 0 1 0 0 0  0 0 0 0 0 0 0 0  0 0 0 00 0 0

/* rv_decoder.f */
+incdir+test
logic/rv_decode_pkg.sv
logic/rv_ctrl_decode.sv
logic/rv_bypass_select.sv
logic/rv_branch_resolve.sv
logic/rv_flow_ctrl.sv
logic/rv_decoder_top.sv
test/rv_decoder_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the decoder testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f rv_decoder.f \
	--top-module rv_decoder_tb \
	-o rv_decoder_sim
./obj_dir/rv_decoder_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* test/rv_decoder_checks.svh */
// Compare tasks for the decoder testbench, one per kind of DUT output
`ifndef RV_DECODER_CHECKS_SVH
`define RV_DECODER_CHECKS_SVH

task automatic report_mismatch(input string what, input string got, input string exp);
	$display("** Error at %0t ns: record %0d, %s is %s, expected %s",
		$time, cur_rec, what, got, exp);
	err_count++;
	test_errs++;
endtask

task automatic check_pc_sel(input string what, input rv_decode_pkg::pc_sel_e got,
	input rv_decode_pkg::pc_sel_e exp);
	if (got !== exp) begin
		report_mismatch(what, got.name(), exp.name());
	end
endtask

task automatic check_byp(input string what, input rv_decode_pkg::byp_sel_e got,
	input rv_decode_pkg::byp_sel_e exp);
	if (got !== exp) begin
		report_mismatch(what, got.name(), exp.name());
	end
endtask

task automatic check_wb_sel(input string what, input rv_decode_pkg::wb_sel_e got,
	input rv_decode_pkg::wb_sel_e exp);
	if (got !== exp) begin
		report_mismatch(what, got.name(), exp.name());
	end
endtask

task automatic check_op2_sel(input string what, input rv_decode_pkg::op2_sel_e got,
	input rv_decode_pkg::op2_sel_e exp);
	if (got !== exp) begin
		report_mismatch(what, got.name(), exp.name());
	end
endtask

task automatic check_lane(input string what, input rv_decode_pkg::store_lane_e got,
	input rv_decode_pkg::store_lane_e exp);
	if (got !== exp) begin
		report_mismatch(what, got.name(), exp.name());
	end
endtask

task automatic check_alu_sel(input string what, input logic [4:0] got, input logic [4:0] exp);
	if (got !== exp) begin
		report_mismatch(what, $sformatf("%05b", got), $sformatf("%05b", exp));
	end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		report_mismatch(what, $sformatf("%0b", got), $sformatf("%0b", exp));
	end
endtask

`endif

/* test/rv_decoder_tb.sv */
// Testbench for the decode-stage control, replaying a per-cycle trace against the DUT
`timescale 1ns/10ps
`default_nettype none

module rv_decoder_tb;

	localparam int XLEN         = rv_decode_pkg::XLEN_DEFAULT;
	localparam int REG_W        = rv_decode_pkg::REG_ADDR_W;
	localparam int MAX_LINES    = 128;
	localparam int NUM_COLS     = 28;
	localparam int NUM_TESTS    = 6;
	localparam int RESET_CYCLES = 10;

	logic                        clk;
	logic                        rst_i;
	rv_decode_pkg::opcode_e      opcode_i;
	logic [2:0]                  func3_i;
	logic [6:0]                  func7_i;
	logic [REG_W-1:0]            prev_rd_i;
	logic [REG_W-1:0]            curr_rs1_i;
	logic [REG_W-1:0]            curr_rs2_i;
	rv_decode_pkg::opcode_e      prev_op_i;
	logic [XLEN-1:0]             rs1_val_i;
	logic [XLEN-1:0]             rs2_val_i;
	logic                        take_br_i;
	logic                        mem_busy_i;
	logic                        alu_busy_i;
	logic [4:0]                  alu_sel_o;
	logic                        alu_en_o;
	logic                        op1_sel_o;
	rv_decode_pkg::op2_sel_e     op2_sel_o;
	rv_decode_pkg::wb_sel_e      wb_sel_o;
	rv_decode_pkg::store_lane_e  store_lane_o;
	logic                        unalign_addr_sel_o;
	rv_decode_pkg::byp_sel_e     rs1_byp_o;
	rv_decode_pkg::byp_sel_e     rs2_byp_o;
	rv_decode_pkg::pc_sel_e      pc_sel_o;
	logic                        pred_miss_o;
	logic                        ir_hold_o;
	logic                        rf_wrten_o;
	logic                        mem_rden_o;
	logic                        mem_wrten_o;
	logic                        div_en_o;
	logic                        unalign_wren_o;

	logic [31:0] trace_mem [MAX_LINES*NUM_COLS];
	logic [31:0] rec [NUM_COLS]; // Current trace record
	int          n_lines;
	int          cur_rec;
	int          seed;
	int          err_count;
	int          test_errs;
	int          tests_run;
	int          tests_failed;
	int          cycle_count = 0;
	int          cycle_limit = MAX_LINES + RESET_CYCLES + 20;

	`include "rv_decoder_checks.svh"

	rv_decoder_top #(
		.XLEN (XLEN)
	) u_rv_decoder_top (
		.clk                (clk),
		.rst_i              (rst_i),
		.opcode_i           (opcode_i),
		.func3_i            (func3_i),
		.func7_i            (func7_i),
		.prev_rd_i          (prev_rd_i),
		.curr_rs1_i         (curr_rs1_i),
		.curr_rs2_i         (curr_rs2_i),
		.prev_op_i          (prev_op_i),
		.rs1_val_i          (rs1_val_i),
		.rs2_val_i          (rs2_val_i),
		.take_br_i          (take_br_i),
		.mem_busy_i         (mem_busy_i),
		.alu_busy_i         (alu_busy_i),
		.alu_sel_o          (alu_sel_o),
		.alu_en_o           (alu_en_o),
		.op1_sel_o          (op1_sel_o),
		.op2_sel_o          (op2_sel_o),
		.wb_sel_o           (wb_sel_o),
		.store_lane_o       (store_lane_o),
		.unalign_addr_sel_o (unalign_addr_sel_o),
		.rs1_byp_o          (rs1_byp_o),
		.rs2_byp_o          (rs2_byp_o),
		.pc_sel_o           (pc_sel_o),
		.pred_miss_o        (pred_miss_o),
		.ir_hold_o          (ir_hold_o),
		.rf_wrten_o         (rf_wrten_o),
		.mem_rden_o         (mem_rden_o),
		.mem_wrten_o        (mem_wrten_o),
		.div_en_o           (div_en_o),
		.unalign_wren_o     (unalign_wren_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Run limit from the trace length
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Run stopped after %0d cycles before the trace was finished", cycle_count);
			$display("Errors found");
			$finish;
		end
	end

	// --------------------
	// Trace handling
	// --------------------
	function automatic bit is_test_id(input logic [31:0] v);
		return (v >= 1 && v <= NUM_TESTS);
	endfunction

	function automatic string test_name(input int id);
		case (id)
			1:       return "bypass";
			2:       return "branch prediction";
			3:       return "memory stall";
			4:       return "sub-word store";
			5:       return "divide";
			6:       return "plain decode";
			default: return "unknown";
		endcase
	endfunction

	// ALU result for U-type, immediate and register ops and the JALR target
	function automatic logic alu_used(input rv_decode_pkg::opcode_e op);
		case (op)
			rv_decode_pkg::OP_LUI,
			rv_decode_pkg::OP_AUIPC,
			rv_decode_pkg::OP_JALR,
			rv_decode_pkg::OP_ARIT_I,
			rv_decode_pkg::OP_ARIT: return 1'b1;
			default:                return 1'b0;
		endcase
	endfunction

	task automatic drive_idle();
		opcode_i   = rv_decode_pkg::OP_ARIT_I;
		func3_i    = 3'b000;
		func7_i    = 7'b0000000;
		prev_rd_i  = '0;
		curr_rs1_i = '0;
		curr_rs2_i = '0;
		prev_op_i  = rv_decode_pkg::OP_ARIT_I;
		rs1_val_i  = '0;
		rs2_val_i  = '0;
		take_br_i  = 1'b0;
		mem_busy_i = 1'b0;
		alu_busy_i = 1'b0;
	endtask

	task automatic apply_record(input int r);
		int k;
		for (k = 0; k < NUM_COLS; k++) begin
			rec[k] = trace_mem[r*NUM_COLS + k];
		end
		cur_rec    = r;
		opcode_i   = rv_decode_pkg::opcode_e'(rec[1][6:0]);
		func3_i    = rec[2][2:0];
		func7_i    = rec[3][6:0];
		prev_rd_i  = rec[4][REG_W-1:0];
		prev_op_i  = rv_decode_pkg::opcode_e'(rec[5][6:0]);
		curr_rs1_i = rec[6][REG_W-1:0];
		curr_rs2_i = rec[7][REG_W-1:0];
		if (rec[10][0]) begin
			rs1_val_i = $random(seed); // Operands unused by this record
			rs2_val_i = $random(seed);
		end else begin
			rs1_val_i = rec[8];
			rs2_val_i = rec[9];
		end
		take_br_i  = rec[11][0];
		mem_busy_i = rec[12][0];
		alu_busy_i = rec[13][0];
	endtask

	task automatic check_record();
		rv_decode_pkg::op2_sel_e    exp_op2;
		rv_decode_pkg::store_lane_e exp_lane;
		exp_op2  = rv_decode_pkg::op2_sel_e'(rec[24][2:0]);
		exp_lane = rv_decode_pkg::store_lane_e'(rec[23][1:0]);
		check_pc_sel("pc_sel", pc_sel_o, rv_decode_pkg::pc_sel_e'(rec[14][2:0]));
		check_bit("pred_miss", pred_miss_o, rec[15][0]);
		check_bit("ir_hold", ir_hold_o, rec[16][0]);
		check_bit("rf_wrten", rf_wrten_o, rec[17][0]);
		check_bit("mem_rden", mem_rden_o, rec[18][0]);
		check_bit("mem_wrten", mem_wrten_o, rec[19][0]);
		check_bit("unalign_wren", unalign_wren_o, rec[20][0]);
		check_bit("div_en", div_en_o, rec[21][0]);
		check_wb_sel("wb_sel", wb_sel_o, rv_decode_pkg::wb_sel_e'(rec[22][3:0]));
		check_lane("store_lane", store_lane_o, exp_lane);
		check_op2_sel("op2_sel", op2_sel_o, exp_op2);
		check_alu_sel("alu_sel", alu_sel_o, rec[25][4:0]);
		check_byp("rs1_byp", rs1_byp_o, rv_decode_pkg::byp_sel_e'(rec[26][1:0]));
		check_byp("rs2_byp", rs2_byp_o, rv_decode_pkg::byp_sel_e'(rec[27][1:0]));
		check_bit("alu_en", alu_en_o, alu_used(opcode_i));
		// U-type ops replace the first operand too
		check_bit("op1_sel", op1_sel_o,
			exp_op2 == rv_decode_pkg::OP2_PC || exp_op2 == rv_decode_pkg::OP2_IMM_U);
		check_bit("unalign_addr_sel", unalign_addr_sel_o, exp_lane != rv_decode_pkg::LANE_NONE);
	endtask

	task automatic report_test(input int id, input int cycles);
		tests_run++;
		if (test_errs != 0) begin
			tests_failed++;
		end
		$display("Test %0d (%s) %s over %0d cycles with %0d mismatches", id, test_name(id),
			(test_errs == 0) ? "passed" : "failed", cycles, test_errs);
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		int r;
		int i;
		int test_cycles;
		seed         = 56963;
		err_count    = 0;
		test_errs    = 0;
		tests_run    = 0;
		tests_failed = 0;
		cur_rec      = 0;
		rst_i        = 1'b1;
		drive_idle();
		for (i = 0; i < MAX_LINES*NUM_COLS; i++) begin
			trace_mem[i] = {1'b1, 31'(i)}; // Never a valid test number
		end
		$readmemh("test/rv_decoder_trace.txt", trace_mem);
		n_lines = 0;
		while (n_lines < MAX_LINES && is_test_id(trace_mem[n_lines*NUM_COLS])) begin
			n_lines++;
		end
		cycle_limit = n_lines + RESET_CYCLES + 20;
		if (n_lines == 0) begin
			$display("The trace file held no test records");
			$display("Errors found");
			$finish;
		end else begin
			repeat (RESET_CYCLES) @(posedge clk);
			test_cycles = 0;
			for (r = 0; r < n_lines; r++) begin
				if (r != 0) begin
					@(posedge clk);
				end
				#2;
				rst_i = 1'b0;
				apply_record(r);
				#17; // Just before the next edge
				check_record();
				test_cycles++;
				if (r == n_lines - 1 || trace_mem[(r + 1)*NUM_COLS] != rec[0]) begin
					report_test(int'(rec[0]), test_cycles);
					test_cycles = 0;
					test_errs   = 0;
				end
			end
			$display("Tests run %0d, tests failed %0d, mismatches %0d",
				tests_run, tests_failed, err_count);
			if (err_count == 0) begin
				$display("No errors");
			end else begin
				$display("Errors found");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

/* logic/rv_decoder_top.sv */
// Decode-stage control top joining decode, bypass, branch and flow blocks
`timescale 1ns/10ps
`default_nettype none

module rv_decoder_top #(
	parameter int XLEN = rv_decode_pkg::XLEN_DEFAULT
) (
	input  logic                                 clk,
	input  logic                                 rst_i,
	input  rv_decode_pkg::opcode_e               opcode_i,
	input  logic [2:0]                           func3_i,
	input  logic [6:0]                           func7_i,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] prev_rd_i,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] curr_rs1_i,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] curr_rs2_i,
	input  rv_decode_pkg::opcode_e               prev_op_i,
	input  logic [XLEN-1:0]                      rs1_val_i,
	input  logic [XLEN-1:0]                      rs2_val_i,
	input  logic                                 take_br_i,
	input  logic                                 mem_busy_i,
	input  logic                                 alu_busy_i,
	output logic [4:0]                           alu_sel_o,
	output logic                                 alu_en_o,
	output logic                                 op1_sel_o,
	output rv_decode_pkg::op2_sel_e              op2_sel_o,
	output rv_decode_pkg::wb_sel_e               wb_sel_o,
	output rv_decode_pkg::store_lane_e           store_lane_o,
	output logic                                 unalign_addr_sel_o,
	output rv_decode_pkg::byp_sel_e              rs1_byp_o,
	output rv_decode_pkg::byp_sel_e              rs2_byp_o,
	output rv_decode_pkg::pc_sel_e               pc_sel_o,
	output logic                                 pred_miss_o,
	output logic                                 ir_hold_o,
	output logic                                 rf_wrten_o,
	output logic                                 mem_rden_o,
	output logic                                 mem_wrten_o,
	output logic                                 div_en_o,
	output logic                                 unalign_wren_o
);

	rv_decode_pkg::flow_req_e flow_req;
	logic                     rf_wr_req;
	logic                     mem_rd_req;
	logic                     mem_wr_req;
	logic                     uses_rs1;
	logic                     uses_rs2;
	logic                     br_cond;

	rv_ctrl_decode u_ctrl_decode (
		.opcode_i           (opcode_i),
		.func3_i            (func3_i),
		.func7_i            (func7_i),
		.alu_sel_o          (alu_sel_o),
		.alu_en_o           (alu_en_o),
		.op1_sel_o          (op1_sel_o),
		.op2_sel_o          (op2_sel_o),
		.wb_sel_o           (wb_sel_o),
		.store_lane_o       (store_lane_o),
		.unalign_addr_sel_o (unalign_addr_sel_o),
		.flow_req_o         (flow_req),
		.rf_wr_req_o        (rf_wr_req),
		.mem_rd_req_o       (mem_rd_req),
		.mem_wr_req_o       (mem_wr_req),
		.uses_rs1_o         (uses_rs1),
		.uses_rs2_o         (uses_rs2)
	);

	rv_bypass_select u_bypass_select (
		.prev_rd_i  (prev_rd_i),
		.prev_op_i  (prev_op_i),
		.curr_rs1_i (curr_rs1_i),
		.curr_rs2_i (curr_rs2_i),
		.uses_rs1_i (uses_rs1),
		.uses_rs2_i (uses_rs2),
		.rs1_byp_o  (rs1_byp_o),
		.rs2_byp_o  (rs2_byp_o)
	);

	rv_branch_resolve #(
		.XLEN (XLEN)
	) u_branch_resolve (
		.rs1_val_i (rs1_val_i),
		.rs2_val_i (rs2_val_i),
		.func3_i   (func3_i),
		.br_cond_o (br_cond)
	);

	rv_flow_ctrl u_flow_ctrl (
		.clk            (clk),
		.rst_i          (rst_i),
		.flow_req_i     (flow_req),
		.rf_wr_req_i    (rf_wr_req),
		.mem_rd_req_i   (mem_rd_req),
		.mem_wr_req_i   (mem_wr_req),
		.br_cond_i      (br_cond),
		.take_br_i      (take_br_i),
		.mem_busy_i     (mem_busy_i),
		.alu_busy_i     (alu_busy_i),
		.pc_sel_o       (pc_sel_o),
		.pred_miss_o    (pred_miss_o),
		.ir_hold_o      (ir_hold_o),
		.rf_wrten_o     (rf_wrten_o),
		.mem_rden_o     (mem_rden_o),
		.mem_wrten_o    (mem_wrten_o),
		.div_en_o       (div_en_o),
		.unalign_wren_o (unalign_wren_o)
	);

endmodule

`default_nettype wire

/* logic/rv_flow_ctrl.sv */
// Flow control for PC steering, pipeline holds, write enables and sub-word store phase
`timescale 1ns/10ps
`default_nettype none

module rv_flow_ctrl (
	input  logic                     clk,
	input  logic                     rst_i,
	input  rv_decode_pkg::flow_req_e flow_req_i,
	input  logic                     rf_wr_req_i,
	input  logic                     mem_rd_req_i,
	input  logic                     mem_wr_req_i,
	input  logic                     br_cond_i,
	input  logic                     take_br_i,
	input  logic                     mem_busy_i,
	input  logic                     alu_busy_i,
	output rv_decode_pkg::pc_sel_e   pc_sel_o,
	output logic                     pred_miss_o,
	output logic                     ir_hold_o,
	output logic                     rf_wrten_o,
	output logic                     mem_rden_o,
	output logic                     mem_wrten_o,
	output logic                     div_en_o,
	output logic                     unalign_wren_o
);

	rv_decode_pkg::rmw_state_e phase_q;
	rv_decode_pkg::rmw_state_e phase_d;

	always_comb begin
		pc_sel_o       = rv_decode_pkg::PC_NEXT;
		pred_miss_o    = 1'b0;
		ir_hold_o      = 1'b0;
		rf_wrten_o     = rf_wr_req_i;
		mem_rden_o     = mem_rd_req_i;
		mem_wrten_o    = mem_wr_req_i;
		div_en_o       = 1'b0;
		unalign_wren_o = 1'b0;
		phase_d        = rv_decode_pkg::RMW_READ;

		case (flow_req_i)
			rv_decode_pkg::FLOW_BRANCH: begin
				if (br_cond_i && !take_br_i) begin
					pc_sel_o    = rv_decode_pkg::PC_BR_TARGET; // Taken, fetch went on
					pred_miss_o = 1'b1;
				end else if (!br_cond_i && take_br_i) begin
					pc_sel_o    = rv_decode_pkg::PC_PREV_PLUS1; // Back to fall-through
					pred_miss_o = 1'b1;
				end
			end
			rv_decode_pkg::FLOW_JUMP_REG: begin
				pc_sel_o    = rv_decode_pkg::PC_JALR_TARGET;
				pred_miss_o = 1'b1;
			end
			rv_decode_pkg::FLOW_MEM_ACCESS: begin
				if (mem_busy_i) begin
					pc_sel_o   = rv_decode_pkg::PC_HOLD;
					ir_hold_o  = 1'b1;
					rf_wrten_o = 1'b0; // Load data not ready yet
				end
			end
			rv_decode_pkg::FLOW_DIVIDE: begin
				if (!alu_busy_i) begin
					pc_sel_o   = rv_decode_pkg::PC_HOLD; // Start divider and wait
					ir_hold_o  = 1'b1;
					div_en_o   = 1'b1;
					rf_wrten_o = 1'b0;
				end
			end
			rv_decode_pkg::FLOW_SUBWORD_STORE: begin
				if (phase_q == rv_decode_pkg::RMW_READ) begin
					pc_sel_o   = rv_decode_pkg::PC_HOLD; // Fetch word to merge into
					ir_hold_o  = 1'b1;
					mem_rden_o = 1'b1;
					phase_d    = rv_decode_pkg::RMW_WRITE;
				end else begin
					unalign_wren_o = 1'b1; // Merged word goes back
				end
			end
			default: begin
				pc_sel_o = rv_decode_pkg::PC_NEXT;
			end
		endcase
	end

	// --------------------
	// Store phase register
	// --------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			phase_q <= rv_decode_pkg::RMW_READ;
		end else begin
			phase_q <= phase_d;
		end
	end

	// Fetch side relies on the IR staying put whenever the PC holds
	assert property (@(posedge clk) disable iff (rst_i)
		pc_sel_o == rv_decode_pkg::PC_HOLD |-> ir_hold_o);

	assert property (@(posedge clk) disable iff (rst_i)
		phase_q == rv_decode_pkg::RMW_WRITE |->
		$past(phase_q == rv_decode_pkg::RMW_READ &&
			flow_req_i == rv_decode_pkg::FLOW_SUBWORD_STORE));

endmodule

`default_nettype wire

/* logic/rv_branch_resolve.sv */
// Branch condition evaluation on the two register operands
`timescale 1ns/10ps
`default_nettype none

module rv_branch_resolve #(
	parameter int XLEN = rv_decode_pkg::XLEN_DEFAULT
) (
	input  logic [XLEN-1:0] rs1_val_i,
	input  logic [XLEN-1:0] rs2_val_i,
	input  logic [2:0]      func3_i,
	output logic            br_cond_o
);

	logic eq;
	logic lt_s;
	logic lt_u;

	assign eq   = (rs1_val_i == rs2_val_i);
	assign lt_s = ($signed(rs1_val_i) < $signed(rs2_val_i));
	assign lt_u = (rs1_val_i < rs2_val_i);

	always_comb begin
		case (rv_decode_pkg::branch_f3_e'(func3_i))
			rv_decode_pkg::F3_BEQ:  br_cond_o = eq;
			rv_decode_pkg::F3_BNE:  br_cond_o = !eq;
			rv_decode_pkg::F3_BLT:  br_cond_o = lt_s;
			rv_decode_pkg::F3_BGE:  br_cond_o = !lt_s;
			rv_decode_pkg::F3_BLTU: br_cond_o = lt_u;
			rv_decode_pkg::F3_BGEU: br_cond_o = !lt_u;
			default:                br_cond_o = 1'b0; // 010, 011 never taken
		endcase
	end

endmodule

`default_nettype wire

/* logic/rv_bypass_select.sv */
// Operand bypass selection from the previous instruction's destination and opcode
`timescale 1ns/10ps
`default_nettype none

module rv_bypass_select (
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] prev_rd_i,
	input  rv_decode_pkg::opcode_e               prev_op_i,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] curr_rs1_i,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] curr_rs2_i,
	input  logic                                 uses_rs1_i,
	input  logic                                 uses_rs2_i,
	output rv_decode_pkg::byp_sel_e              rs1_byp_o,
	output rv_decode_pkg::byp_sel_e              rs2_byp_o
);

	// Same rule for both source operands
	function automatic rv_decode_pkg::byp_sel_e pick_src(
		input logic [rv_decode_pkg::REG_ADDR_W-1:0] rs,
		input logic                                 used,
		input logic [rv_decode_pkg::REG_ADDR_W-1:0] prev_rd,
		input rv_decode_pkg::opcode_e               prev_op
	);
		rv_decode_pkg::byp_sel_e src;
		src = rv_decode_pkg::BYP_REGFILE;
		if (used && rs == prev_rd && prev_rd != '0) begin
			case (prev_op)
				rv_decode_pkg::OP_LOAD:   src = rv_decode_pkg::BYP_MEM;
				rv_decode_pkg::OP_LUI,
				rv_decode_pkg::OP_AUIPC,
				rv_decode_pkg::OP_JAL,
				rv_decode_pkg::OP_JALR,
				rv_decode_pkg::OP_ARIT,
				rv_decode_pkg::OP_ARIT_I,
				rv_decode_pkg::OP_SYSTEM: src = rv_decode_pkg::BYP_ALU;
				default:                  src = rv_decode_pkg::BYP_REGFILE; // Store, branch
			endcase
		end
		return src;
	endfunction

	assign rs1_byp_o = pick_src(curr_rs1_i, uses_rs1_i, prev_rd_i, prev_op_i);
	assign rs2_byp_o = pick_src(curr_rs2_i, uses_rs2_i, prev_rd_i, prev_op_i);

	// x0 never forwards
	always_comb begin
		if (prev_rd_i == '0) begin
			assert (rs1_byp_o == rv_decode_pkg::BYP_REGFILE &&
				rs2_byp_o == rv_decode_pkg::BYP_REGFILE)
				else $error("Bypass selected with prev_rd zero");
		end
	end

endmodule

`default_nettype wire

/* logic/rv_ctrl_decode.sv */
// Control decode turning opcode, func3 and func7 into datapath selects and flow requests
`timescale 1ns/10ps
`default_nettype none

module rv_ctrl_decode (
	input  rv_decode_pkg::opcode_e     opcode_i,
	input  logic [2:0]                 func3_i,
	input  logic [6:0]                 func7_i,
	output logic [4:0]                 alu_sel_o,
	output logic                       alu_en_o,
	output logic                       op1_sel_o,
	output rv_decode_pkg::op2_sel_e    op2_sel_o,
	output rv_decode_pkg::wb_sel_e     wb_sel_o,
	output rv_decode_pkg::store_lane_e store_lane_o,
	output logic                       unalign_addr_sel_o,
	output rv_decode_pkg::flow_req_e   flow_req_o,
	output logic                       rf_wr_req_o,
	output logic                       mem_rd_req_o,
	output logic                       mem_wr_req_o,
	output logic                       uses_rs1_o,
	output logic                       uses_rs2_o
);

	localparam logic [6:0] FUNC7_MULDIV = 7'b0000001;

	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SR  = 3'b101;

	logic is_muldiv;
	logic is_shift;

	assign is_muldiv = (func7_i == FUNC7_MULDIV);
	assign is_shift  = (func3_i == F3_SLL) || (func3_i == F3_SR);

	always_comb begin
		alu_sel_o          = 5'b00000;
		alu_en_o           = 1'b0;
		op1_sel_o          = 1'b0;
		op2_sel_o          = rv_decode_pkg::OP2_RS2;
		wb_sel_o           = rv_decode_pkg::WB_ALU_LO;
		store_lane_o       = rv_decode_pkg::LANE_NONE;
		unalign_addr_sel_o = 1'b0;
		flow_req_o         = rv_decode_pkg::FLOW_NONE;
		rf_wr_req_o        = 1'b0;
		mem_rd_req_o       = 1'b0;
		mem_wr_req_o       = 1'b0;
		uses_rs1_o         = 1'b0;
		uses_rs2_o         = 1'b0;

		case (opcode_i)
			rv_decode_pkg::OP_LUI: begin
				alu_en_o    = 1'b1;
				op1_sel_o   = 1'b1;
				op2_sel_o   = rv_decode_pkg::OP2_IMM_U;
				rf_wr_req_o = 1'b1;
			end
			rv_decode_pkg::OP_AUIPC: begin
				alu_en_o    = 1'b1;
				op1_sel_o   = 1'b1;
				op2_sel_o   = rv_decode_pkg::OP2_PC;
				rf_wr_req_o = 1'b1;
			end
			rv_decode_pkg::OP_JAL: begin
				wb_sel_o    = rv_decode_pkg::WB_LINK_PC; // Target resolved at fetch
				rf_wr_req_o = 1'b1;
			end
			rv_decode_pkg::OP_JALR: begin
				alu_en_o    = 1'b1;
				op2_sel_o   = rv_decode_pkg::OP2_IMM_I;
				wb_sel_o    = rv_decode_pkg::WB_LINK_PC;
				flow_req_o  = rv_decode_pkg::FLOW_JUMP_REG;
				rf_wr_req_o = 1'b1;
				uses_rs1_o  = 1'b1;
			end
			rv_decode_pkg::OP_BRANCH: begin
				alu_sel_o  = {2'b00, func3_i};
				flow_req_o = rv_decode_pkg::FLOW_BRANCH;
				uses_rs1_o = 1'b1;
				uses_rs2_o = 1'b1;
			end
			rv_decode_pkg::OP_LOAD: begin
				op2_sel_o    = rv_decode_pkg::OP2_IMM_I; // Base plus offset
				flow_req_o   = rv_decode_pkg::FLOW_MEM_ACCESS;
				rf_wr_req_o  = 1'b1;
				mem_rd_req_o = 1'b1;
				uses_rs1_o   = 1'b1;
				case (func3_i)
					F3_LW:   wb_sel_o = rv_decode_pkg::WB_MEM_WORD;
					F3_LB:   wb_sel_o = rv_decode_pkg::WB_MEM_BYTE_S;
					F3_LBU:  wb_sel_o = rv_decode_pkg::WB_MEM_BYTE_U;
					F3_LH:   wb_sel_o = rv_decode_pkg::WB_MEM_HALF_S;
					F3_LHU:  wb_sel_o = rv_decode_pkg::WB_MEM_HALF_U;
					default: wb_sel_o = rv_decode_pkg::WB_ALU_LO;
				endcase
			end
			rv_decode_pkg::OP_STORE: begin
				op2_sel_o  = rv_decode_pkg::OP2_IMM_S;
				uses_rs1_o = 1'b1;
				uses_rs2_o = 1'b1;
				case (func3_i)
					F3_SW: begin
						flow_req_o   = rv_decode_pkg::FLOW_MEM_ACCESS;
						mem_wr_req_o = 1'b1;
					end
					F3_SB: begin
						store_lane_o       = rv_decode_pkg::LANE_BYTE;
						unalign_addr_sel_o = 1'b1; // Word-aligned read address
						flow_req_o         = rv_decode_pkg::FLOW_SUBWORD_STORE;
					end
					F3_SH: begin
						store_lane_o       = rv_decode_pkg::LANE_HALF;
						unalign_addr_sel_o = 1'b1;
						flow_req_o         = rv_decode_pkg::FLOW_SUBWORD_STORE;
					end
					default: flow_req_o = rv_decode_pkg::FLOW_NONE;
				endcase
			end
			rv_decode_pkg::OP_ARIT_I: begin
				// Shift immediates carry the arithmetic flag in func7
				alu_sel_o   = is_shift ? {func7_i[5], func7_i[0], func3_i} : {2'b00, func3_i};
				alu_en_o    = 1'b1;
				op2_sel_o   = rv_decode_pkg::OP2_IMM_I;
				rf_wr_req_o = 1'b1;
				uses_rs1_o  = 1'b1;
			end
			rv_decode_pkg::OP_ARIT: begin
				alu_sel_o   = {func7_i[5], func7_i[0], func3_i};
				alu_en_o    = 1'b1;
				rf_wr_req_o = 1'b1;
				uses_rs1_o  = 1'b1;
				uses_rs2_o  = 1'b1;
				if (is_muldiv && func3_i[2]) begin
					flow_req_o = rv_decode_pkg::FLOW_DIVIDE; // DIV, DIVU, REM, REMU
				end else if (is_muldiv && func3_i != 3'b000) begin
					wb_sel_o = rv_decode_pkg::WB_ALU_HI; // MULH variants
				end
			end
			default: begin
				flow_req_o = rv_decode_pkg::FLOW_NONE; // SYSTEM and unknown opcodes
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/rv_decode_pkg.sv */
// Decoder package with opcode, select and phase enums and width constants
`default_nettype none

package rv_decode_pkg;

	localparam int XLEN_DEFAULT = 32;
	localparam int REG_ADDR_W   = 5;

	// --------------------
	// Instruction fields
	// --------------------
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_ARIT_I = 7'b0010011,
		OP_ARIT   = 7'b0110011,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		F3_BEQ  = 3'b000,
		F3_BNE  = 3'b001,
		F3_BLT  = 3'b100,
		F3_BGE  = 3'b101,
		F3_BLTU = 3'b110,
		F3_BGEU = 3'b111
	} branch_f3_e;

	// --------------------
	// Datapath selects
	// --------------------
	typedef enum logic [2:0] {
		OP2_RS2   = 3'b000,
		OP2_IMM_I = 3'b001,
		OP2_IMM_S = 3'b010,
		OP2_PC    = 3'b011,
		OP2_IMM_U = 3'b100
	} op2_sel_e;

	typedef enum logic [3:0] {
		WB_ALU_LO     = 4'b0000,
		WB_MEM_WORD   = 4'b0001,
		WB_LINK_PC    = 4'b0010,
		WB_MEM_BYTE_U = 4'b0011,
		WB_MEM_HALF_U = 4'b0100,
		WB_MEM_BYTE_S = 4'b0101,
		WB_MEM_HALF_S = 4'b0110,
		WB_ALU_HI     = 4'b0111
	} wb_sel_e;

	typedef enum logic [2:0] {
		PC_NEXT        = 3'b000,
		PC_BR_TARGET   = 3'b001,
		PC_JALR_TARGET = 3'b010,
		PC_PREV_PLUS1  = 3'b011,
		PC_HOLD        = 3'b100
	} pc_sel_e;

	typedef enum logic [1:0] {
		BYP_REGFILE = 2'b00,
		BYP_ALU     = 2'b01,
		BYP_MEM     = 2'b10
	} byp_sel_e;

	typedef enum logic [1:0] {
		LANE_NONE = 2'b00,
		LANE_BYTE = 2'b01,
		LANE_HALF = 2'b10
	} store_lane_e;

	// --------------------
	// Flow control
	// --------------------
	typedef enum logic [2:0] {
		FLOW_NONE,
		FLOW_BRANCH,
		FLOW_JUMP_REG,
		FLOW_MEM_ACCESS,
		FLOW_DIVIDE,
		FLOW_SUBWORD_STORE
	} flow_req_e;

	typedef enum logic {
		RMW_READ,
		RMW_WRITE
	} rmw_state_e;

endpackage

`default_nettype wire
